/* design/addr_decoder.sv */
`timescale 1ns/100ps

module addr_decoder (
    input  axil_pkg::addr_t                                 addr_i,
    input  xbar_cfg_pkg::rule_t [xbar_cfg_pkg::NO_SUBS-1:0] addr_map_i,
    output xbar_cfg_pkg::sub_idx_t                          sel_o,
    output axil_pkg::addr_t                                 local_addr_o,
    output logic                                            hit_o
);

    logic [xbar_cfg_pkg::NO_SUBS-1:0] match;

    always_comb begin
        for (int i = 0; i < xbar_cfg_pkg::NO_SUBS; i++) begin
            match[i] = (addr_i >= addr_map_i[i].start_addr)
                       && (addr_i < addr_map_i[i].end_addr);
        end
    end

    // Walking down the table leaves the lowest matching rule in place,
    // so the first rule wins when two of them overlap.
    always_comb begin
        sel_o        = '0;
        local_addr_o = '0;
        for (int i = xbar_cfg_pkg::NO_SUBS - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_o        = addr_map_i[i].idx;
                local_addr_o = addr_i - addr_map_i[i].start_addr; // offset inside the rule.
            end
        end
    end

    assign hit_o = |match; // a miss is answered locally by the switch.

endmodule

/* design/axil_pkg.sv */
package axil_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11; // no subordinate behind this address.

    // Everything a manager drives on the five AXI-Lite channels.
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axil_req_t;

    // Everything a subordinate drives back.
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axil_resp_t;

endpackage

/* design/axil_port_stage.sv */
`timescale 1ns/100ps

module axil_port_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 pause_req_i,
    input  axil_pkg::axil_req_t  mgr_req_i,
    output axil_pkg::axil_resp_t mgr_resp_o,
    output axil_pkg::axil_req_t  stg_req_o,
    input  axil_pkg::axil_resp_t stg_resp_i,
    output logic                 drained_o
);

    // One held request, either a write with its data or a read.
    typedef struct packed {
        logic            wr;
        axil_pkg::addr_t addr;
        axil_pkg::data_t data;
        axil_pkg::strb_t strb;
    } hold_t;

    hold_t                    hold_q;
    logic                     full_q;
    xbar_cfg_pkg::trans_cnt_t cnt_q;

    logic can_take;
    logic take_wr;
    logic take_rd;
    logic pass;
    logic done;

    // A pending pause closes the stage to new requests.
    assign can_take = !full_q && !pause_req_i && (cnt_q != xbar_cfg_pkg::MAX_TRANS);

    assign take_wr = can_take && mgr_req_i.aw_valid && mgr_req_i.w_valid;
    assign take_rd = can_take && mgr_req_i.ar_valid
                     && !(mgr_req_i.aw_valid && mgr_req_i.w_valid); // writes go first.

    assign pass = full_q && (hold_q.wr ? (stg_resp_i.aw_ready && stg_resp_i.w_ready)
                                       : stg_resp_i.ar_ready);

    assign done = (stg_resp_i.b_valid && mgr_req_i.b_ready)
                  || (stg_resp_i.r_valid && mgr_req_i.r_ready);

    always_comb begin
        mgr_resp_o          = stg_resp_i; // B and R go back without a register.
        mgr_resp_o.aw_ready = take_wr;
        mgr_resp_o.w_ready  = take_wr;
        mgr_resp_o.ar_ready = take_rd;
    end

    always_comb begin
        stg_req_o          = mgr_req_i; // b_ready and r_ready pass through.
        stg_req_o.aw_valid = full_q && hold_q.wr;
        stg_req_o.aw_addr  = hold_q.addr;
        stg_req_o.w_valid  = full_q && hold_q.wr;
        stg_req_o.w_data   = hold_q.data;
        stg_req_o.w_strb   = hold_q.strb;
        stg_req_o.ar_valid = full_q && !hold_q.wr;
        stg_req_o.ar_addr  = hold_q.addr;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (take_wr || take_rd) begin
            full_q <= 1'b1;
        end else if (pass) begin
            full_q <= 1'b0; // the switch has taken the request.
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_wr || take_rd) begin
            hold_q.wr   <= take_wr;
            hold_q.addr <= take_wr ? mgr_req_i.aw_addr : mgr_req_i.ar_addr;
            hold_q.data <= mgr_req_i.w_data;
            hold_q.strb <= mgr_req_i.w_strb;
        end
    end

    // Counts from acceptance at the manager until B or R is handed back.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if ((take_wr || take_rd) && !done) begin
            if (cnt_q != xbar_cfg_pkg::MAX_TRANS) begin
                cnt_q <= cnt_q + 3'd1;
            end
        end else if (done && !(take_wr || take_rd) && (cnt_q != '0)) begin
            cnt_q <= cnt_q - 3'd1;
        end
    end

    assign drained_o = (cnt_q == '0) && !full_q;

endmodule

/* design/axil_switch.sv */
`timescale 1ns/100ps

module axil_switch (
    input  logic                                                   clk_i,
    input  logic                                                   rst_n_i,
    input  logic                                                   pause_req_i,
    input  axil_pkg::axil_req_t  [xbar_cfg_pkg::NO_MGRS-1:0]       stg_req_i,
    output axil_pkg::axil_resp_t [xbar_cfg_pkg::NO_MGRS-1:0]       stg_resp_o,
    input  logic                 [xbar_cfg_pkg::NO_MGRS-1:0]       drained_i,
    output axil_pkg::addr_t                                        dec_addr_o,
    input  xbar_cfg_pkg::sub_idx_t                                 dec_sel_i,
    input  axil_pkg::addr_t                                        dec_local_addr_i,
    input  logic                                                   dec_hit_i,
    output axil_pkg::axil_req_t  [xbar_cfg_pkg::NO_SUBS-1:0]       sub_req_o,
    input  axil_pkg::axil_resp_t [xbar_cfg_pkg::NO_SUBS-1:0]       sub_resp_i,
    output logic                                                   pause_ack_o
);

    typedef enum logic [2:0] {IDLE, REQ, RESP, DECERR, RETURN} state_e;

    // The one transaction the switch carries at a time.
    typedef struct packed {
        logic                   wr;
        xbar_cfg_pkg::sub_idx_t sel;
        axil_pkg::addr_t        addr;
        axil_pkg::data_t        data;
        axil_pkg::strb_t        strb;
    } txn_t;

    typedef struct packed {
        axil_pkg::resp_t resp;
        axil_pkg::data_t data;
    } rsp_t;

    state_e                 state_q;
    logic                   accept_q;
    xbar_cfg_pkg::mgr_idx_t gnt_q;
    xbar_cfg_pkg::mgr_idx_t rr_q;
    xbar_cfg_pkg::mgr_idx_t winner;
    logic                   ack_q;
    txn_t                   txn_q;
    rsp_t                   rsp_q;

    logic [xbar_cfg_pkg::NO_MGRS-1:0] req_valid;
    logic                             gnt_wr;
    logic                             accepting;
    logic                             sub_taken;
    logic                             sub_answered;
    logic                             mgr_taken;

    always_comb begin
        for (int m = 0; m < xbar_cfg_pkg::NO_MGRS; m++) begin
            req_valid[m] = stg_req_i[m].ar_valid
                           || (stg_req_i[m].aw_valid && stg_req_i[m].w_valid);
        end
    end

    // Search from the pointer upwards, the nearest valid stage wins.
    always_comb begin
        winner = rr_q;
        for (int i = xbar_cfg_pkg::NO_MGRS - 1; i >= 0; i--) begin
            if (req_valid[xbar_cfg_pkg::mgr_idx_t'(int'(rr_q) + i)]) begin
                winner = xbar_cfg_pkg::mgr_idx_t'(int'(rr_q) + i);
            end
        end
    end

    assign accepting = (state_q == IDLE) && accept_q;
    assign gnt_wr    = stg_req_i[gnt_q].aw_valid && stg_req_i[gnt_q].w_valid;
    assign dec_addr_o = gnt_wr ? stg_req_i[gnt_q].aw_addr : stg_req_i[gnt_q].ar_addr;

    assign sub_taken = txn_q.wr ? (sub_resp_i[txn_q.sel].aw_ready
                                   && sub_resp_i[txn_q.sel].w_ready)
                                : sub_resp_i[txn_q.sel].ar_ready;
    assign sub_answered = txn_q.wr ? sub_resp_i[txn_q.sel].b_valid
                                   : sub_resp_i[txn_q.sel].r_valid;
    assign mgr_taken = txn_q.wr ? stg_req_i[gnt_q].b_ready : stg_req_i[gnt_q].r_ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            accept_q <= 1'b0;
            gnt_q    <= '0;
            rr_q     <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept_q) begin
                        accept_q <= 1'b0;
                        rr_q     <= gnt_q + 1'b1; // the winner goes to the back.
                        state_q  <= dec_hit_i ? REQ : DECERR;
                    end else if (|req_valid) begin
                        accept_q <= 1'b1;
                        gnt_q    <= winner;
                    end
                end
                REQ: begin
                    if (sub_taken) begin
                        state_q <= RESP;
                    end
                end
                RESP: begin
                    if (sub_answered) begin
                        state_q <= RETURN;
                    end
                end
                DECERR: state_q <= RETURN;
                RETURN: begin
                    if (mgr_taken) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accepting) begin
            txn_q.wr   <= gnt_wr;
            txn_q.sel  <= dec_sel_i;
            txn_q.addr <= dec_local_addr_i; // start of the rule already removed.
            txn_q.data <= stg_req_i[gnt_q].w_data;
            txn_q.strb <= stg_req_i[gnt_q].w_strb;
        end
        if ((state_q == RESP) && sub_answered) begin
            rsp_q.resp <= txn_q.wr ? sub_resp_i[txn_q.sel].b_resp
                                   : sub_resp_i[txn_q.sel].r_resp;
            rsp_q.data <= sub_resp_i[txn_q.sel].r_data;
        end
        if (state_q == DECERR) begin
            rsp_q.resp <= axil_pkg::RESP_DECERR;
            rsp_q.data <= '0;
        end
    end

    always_comb begin
        sub_req_o = '0;
        if (state_q == REQ) begin
            sub_req_o[txn_q.sel].aw_valid = txn_q.wr;
            sub_req_o[txn_q.sel].aw_addr  = txn_q.addr;
            sub_req_o[txn_q.sel].w_valid  = txn_q.wr;
            sub_req_o[txn_q.sel].w_data   = txn_q.data;
            sub_req_o[txn_q.sel].w_strb   = txn_q.strb;
            sub_req_o[txn_q.sel].ar_valid = !txn_q.wr;
            sub_req_o[txn_q.sel].ar_addr  = txn_q.addr;
        end
        if (state_q == RESP) begin
            sub_req_o[txn_q.sel].b_ready = txn_q.wr;
            sub_req_o[txn_q.sel].r_ready = !txn_q.wr;
        end
    end

    always_comb begin
        stg_resp_o = '0;
        if (accepting) begin
            stg_resp_o[gnt_q].aw_ready = gnt_wr;
            stg_resp_o[gnt_q].w_ready  = gnt_wr;
            stg_resp_o[gnt_q].ar_ready = !gnt_wr;
        end
        if (state_q == RETURN) begin
            stg_resp_o[gnt_q].b_valid = txn_q.wr;
            stg_resp_o[gnt_q].b_resp  = rsp_q.resp;
            stg_resp_o[gnt_q].r_valid = !txn_q.wr;
            stg_resp_o[gnt_q].r_data  = rsp_q.data;
            stg_resp_o[gnt_q].r_resp  = rsp_q.resp;
        end
    end

    // Acknowledge only with every port empty and nothing inside the switch.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= pause_req_i && (&drained_i) && (state_q == IDLE) && !accept_q;
        end
    end

    assign pause_ack_o = ack_q;

endmodule

/* design/axil_xbar_top.sv */
`timescale 1ns/100ps

module axil_xbar_top (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  logic                                                pause_req_i,
    output logic                                                pause_ack_o,
    input  axil_pkg::axil_req_t  [xbar_cfg_pkg::NO_MGRS-1:0]    mgr_req_i,
    output axil_pkg::axil_resp_t [xbar_cfg_pkg::NO_MGRS-1:0]    mgr_resp_o,
    output axil_pkg::axil_req_t  [xbar_cfg_pkg::NO_SUBS-1:0]    sub_req_o,
    input  axil_pkg::axil_resp_t [xbar_cfg_pkg::NO_SUBS-1:0]    sub_resp_i,
    input  xbar_cfg_pkg::rule_t  [xbar_cfg_pkg::NO_SUBS-1:0]    addr_map_i
);

    axil_pkg::axil_req_t  [xbar_cfg_pkg::NO_MGRS-1:0] stg_req;
    axil_pkg::axil_resp_t [xbar_cfg_pkg::NO_MGRS-1:0] stg_resp;
    logic                 [xbar_cfg_pkg::NO_MGRS-1:0] stg_drained;

    axil_pkg::addr_t        dec_addr;
    xbar_cfg_pkg::sub_idx_t dec_sel;
    axil_pkg::addr_t        dec_local_addr;
    logic                   dec_hit;

    // One registered stage in front of every manager port.
    for (genvar i = 0; i < xbar_cfg_pkg::NO_MGRS; i++) begin : g_stage
        axil_port_stage u_port_stage (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .pause_req_i (pause_req_i),
            .mgr_req_i   (mgr_req_i[i]),
            .mgr_resp_o  (mgr_resp_o[i]),
            .stg_req_o   (stg_req[i]),
            .stg_resp_i  (stg_resp[i]),
            .drained_o   (stg_drained[i])
        );
    end

    addr_decoder u_addr_decoder (
        .addr_i       (dec_addr),
        .addr_map_i   (addr_map_i),
        .sel_o        (dec_sel),
        .local_addr_o (dec_local_addr),
        .hit_o        (dec_hit)
    );

    axil_switch u_switch (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .pause_req_i      (pause_req_i),
        .stg_req_i        (stg_req),
        .stg_resp_o       (stg_resp),
        .drained_i        (stg_drained),
        .dec_addr_o       (dec_addr),
        .dec_sel_i        (dec_sel),
        .dec_local_addr_i (dec_local_addr),
        .dec_hit_i        (dec_hit),
        .sub_req_o        (sub_req_o),
        .sub_resp_i       (sub_resp_i),
        .pause_ack_o      (pause_ack_o)
    );

endmodule

/* design/xbar_cfg_pkg.sv */
package xbar_cfg_pkg;

    localparam int NO_MGRS = 2;
    localparam int NO_SUBS = 2;

    typedef logic [2:0] trans_cnt_t; // outstanding transactions of one manager port.

    // The counter saturates here and the port stops taking requests.
    localparam trans_cnt_t MAX_TRANS = 3'd7;

    typedef logic [0:0] mgr_idx_t;
    typedef logic [0:0] sub_idx_t;

    // A rule covers start_addr up to, but not including, end_addr.
    typedef struct packed {
        sub_idx_t        idx;
        axil_pkg::addr_t start_addr;
        axil_pkg::addr_t end_addr;
    } rule_t;

endpackage

/* sources.f */
design/axil_pkg.sv
design/xbar_cfg_pkg.sv
design/axil_port_stage.sv
design/addr_decoder.sv
design/axil_switch.sv
design/axil_xbar_top.sv
test/axil_mem_model.sv
test/tb_axil_xbar.sv

/* test/axil_mem_model.sv */
`timescale 1ns/100ps

module axil_mem_model #(
    parameter logic [31:0] SEED = 32'h1,
    parameter logic [31:0] FILL = 32'h0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  axil_pkg::axil_req_t  req_i,
    output axil_pkg::axil_resp_t resp_o,
    output axil_pkg::addr_t      last_addr_o,
    output int                   req_count_o
);

    axil_pkg::data_t mem [64];
    logic [31:0]     rng_q;
    logic [1:0]      wait_q;
    logic            busy;
    logic            wr_req;

    function automatic logic [31:0] rng_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        resp_o = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = FILL ^ (32'(i) << 2); // every word differs from its neighbours.
        end
    end

    assign wr_req = req_i.aw_valid && req_i.w_valid;
    assign busy   = resp_o.aw_ready || resp_o.ar_ready || resp_o.b_valid || resp_o.r_valid;

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            resp_o      <= '0;
            rng_q       <= SEED;
            wait_q      <= '0;
            last_addr_o <= '0;
            req_count_o <= 0;
        end else begin
            resp_o.aw_ready <= 1'b0;
            resp_o.w_ready  <= 1'b0;
            resp_o.ar_ready <= 1'b0;
            if (resp_o.b_valid && req_i.b_ready) begin
                resp_o.b_valid <= 1'b0;
            end
            if (resp_o.r_valid && req_i.r_ready) begin
                resp_o.r_valid <= 1'b0;
            end
            if (resp_o.aw_ready && wr_req) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.w_strb[b]) begin
                        mem[req_i.aw_addr[7:2]][8*b +: 8] <= req_i.w_data[8*b +: 8];
                    end
                end
                resp_o.b_valid <= 1'b1;
                resp_o.b_resp  <= axil_pkg::RESP_OKAY;
                last_addr_o    <= req_i.aw_addr;
                req_count_o    <= req_count_o + 1;
            end else if (resp_o.ar_ready && req_i.ar_valid) begin
                resp_o.r_valid <= 1'b1;
                resp_o.r_data  <= mem[req_i.ar_addr[7:2]];
                resp_o.r_resp  <= axil_pkg::RESP_OKAY;
                last_addr_o    <= req_i.ar_addr;
                req_count_o    <= req_count_o + 1;
            end else if (!busy && (wr_req || req_i.ar_valid)) begin
                if (wait_q == 2'd0) begin
                    resp_o.aw_ready <= wr_req;
                    resp_o.w_ready  <= wr_req;
                    resp_o.ar_ready <= !wr_req;
                    rng_q           <= rng_step(rng_q);
                    wait_q          <= rng_q[17:16]; // delay before the next request.
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

/* test/tb_axil_xbar.sv */
`timescale 1ns/100ps

module tb_axil_xbar;

    localparam logic [31:0]     SEED      = 32'h10000cfd;
    localparam logic [31:0]     FILL0     = 32'hc0de_0000;
    localparam logic [31:0]     FILL1     = 32'hbeef_0000;
    localparam axil_pkg::addr_t S0_BASE   = 32'h1000_0000;
    localparam axil_pkg::addr_t S1_BASE   = 32'h2000_0000;
    localparam axil_pkg::addr_t RULE_SIZE = 32'h0000_1000;
    localparam int TXN_COUNT   = 62; // 4 + 4 + 3 + 8 + 3 + 40 transactions.
    localparam int CYCLE_LIMIT = 40 * TXN_COUNT;

    logic clk;
    logic rst_n;
    logic pause_req;
    logic pause_ack;
    int   cycles = 0;

    axil_pkg::axil_req_t  [1:0] mgr_req;
    axil_pkg::axil_resp_t [1:0] mgr_resp;
    axil_pkg::axil_req_t  [1:0] sub_req;
    axil_pkg::axil_resp_t [1:0] sub_resp;
    xbar_cfg_pkg::rule_t  [1:0] addr_map;
    axil_pkg::addr_t            last_addr [2];
    int                         req_seen [2];
    axil_pkg::data_t            shadow [2][64]; // expected contents of both memories.

    axil_xbar_top u_axil_xbar_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .pause_req_i (pause_req),
        .pause_ack_o (pause_ack),
        .mgr_req_i   (mgr_req),
        .mgr_resp_o  (mgr_resp),
        .sub_req_o   (sub_req),
        .sub_resp_i  (sub_resp),
        .addr_map_i  (addr_map)
    );

    axil_mem_model #(.SEED(SEED), .FILL(FILL0)) u_mem0 (
        .clk_i (clk), .rst_n_i (rst_n), .req_i (sub_req[0]), .resp_o (sub_resp[0]),
        .last_addr_o (last_addr[0]), .req_count_o (req_seen[0])
    );

    axil_mem_model #(.SEED(~SEED), .FILL(FILL1)) u_mem1 (
        .clk_i (clk), .rst_n_i (rst_n), .req_i (sub_req[1]), .resp_o (sub_resp[1]),
        .last_addr_o (last_addr[1]), .req_count_o (req_seen[1])
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Returns the subordinate behind an address, or -1 when no rule covers it.
    function automatic int sub_of(input axil_pkg::addr_t addr);
        if ((addr >= S0_BASE) && (addr < S0_BASE + RULE_SIZE)) begin
            return 0;
        end
        if ((addr >= S1_BASE) && (addr < S1_BASE + RULE_SIZE)) begin
            return 1;
        end
        return -1;
    endfunction

    task automatic write_and_score(input int m, input axil_pkg::addr_t addr,
                                   input axil_pkg::data_t data, input axil_pkg::strb_t strb);
        int s;
        s = sub_of(addr);
        @(negedge clk);
        mgr_req[m].aw_valid = 1'b1;
        mgr_req[m].aw_addr  = addr;
        mgr_req[m].w_valid  = 1'b1;
        mgr_req[m].w_data   = data;
        mgr_req[m].w_strb   = strb;
        #1;
        while (!mgr_resp[m].aw_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        mgr_req[m].aw_valid = 1'b0;
        mgr_req[m].w_valid  = 1'b0;
        mgr_req[m].b_ready  = 1'b1;
        #1;
        while (!mgr_resp[m].b_valid) begin
            @(negedge clk);
            #1;
        end
        check(mgr_resp[m].b_resp, (s < 0) ? axil_pkg::RESP_DECERR : axil_pkg::RESP_OKAY,
              "write response");
        @(negedge clk);
        mgr_req[m].b_ready = 1'b0;
        if (s >= 0) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[s][addr[7:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic read_and_compare(input int m, input axil_pkg::addr_t addr,
                                    output axil_pkg::data_t data);
        int s;
        s = sub_of(addr);
        @(negedge clk);
        mgr_req[m].ar_valid = 1'b1;
        mgr_req[m].ar_addr  = addr;
        #1;
        while (!mgr_resp[m].ar_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        mgr_req[m].ar_valid = 1'b0;
        mgr_req[m].r_ready  = 1'b1;
        #1;
        while (!mgr_resp[m].r_valid) begin
            @(negedge clk);
            #1;
        end
        data = mgr_resp[m].r_data;
        check(mgr_resp[m].r_resp, (s < 0) ? axil_pkg::RESP_DECERR : axil_pkg::RESP_OKAY,
              "read response");
        check(data, (s < 0) ? 32'h0 : shadow[s][addr[7:2]], "read data");
        @(negedge clk);
        mgr_req[m].r_ready = 1'b0;
    endtask

    task automatic route_and_offset();
        axil_pkg::data_t data;
        write_and_score(0, S0_BASE + 32'h24, 32'h1234_5678, 4'hf);
        check(last_addr[0], 32'h24, "local write address at subordinate 0");
        read_and_compare(1, S0_BASE + 32'h24, data);
        check(last_addr[0], 32'h24, "local read address at subordinate 0");
        write_and_score(1, S1_BASE + 32'h88, 32'h9abc_def0, 4'hf);
        check(last_addr[1], 32'h88, "local write address at subordinate 1");
        read_and_compare(0, S1_BASE + 32'h88, data);
        check(last_addr[1], 32'h88, "local read address at subordinate 1");
    endtask

    task automatic decode_miss();
        axil_pkg::data_t data;
        int              seen0;
        int              seen1;
        seen0 = req_seen[0];
        seen1 = req_seen[1];
        write_and_score(0, 32'h3000_0040, 32'hdead_beef, 4'hf);
        read_and_compare(0, 32'h3000_0040, data);
        write_and_score(1, S0_BASE + RULE_SIZE, 32'h0123_4567, 4'hf); // end is exclusive.
        read_and_compare(1, S1_BASE + RULE_SIZE, data);
        check(req_seen[0], seen0, "requests seen by subordinate 0 on a miss");
        check(req_seen[1], seen1, "requests seen by subordinate 1 on a miss");
    endtask

    task automatic partial_strobes();
        axil_pkg::data_t data;
        write_and_score(0, S1_BASE + 32'h40, 32'h1122_3344, 4'hf);
        write_and_score(0, S1_BASE + 32'h40, 32'haabb_ccdd, 4'b0101);
        read_and_compare(1, S1_BASE + 32'h40, data);
        check(data, 32'h11bb_33dd, "word after a partial write");
    endtask

    // Manager 0 keeps to even words and manager 1 to odd ones.
    task automatic concurrent_traffic();
        axil_pkg::data_t d0;
        axil_pkg::data_t d1;
        fork
            begin
                write_and_score(0, S0_BASE + 32'h08, 32'ha0a0_0001, 4'hf);
                read_and_compare(0, S0_BASE + 32'h08, d0);
                write_and_score(0, S1_BASE + 32'h10, 32'ha0a0_0002, 4'hf);
                read_and_compare(0, S1_BASE + 32'h10, d0);
            end
            begin
                write_and_score(1, S0_BASE + 32'h0c, 32'hb1b1_0001, 4'hf);
                read_and_compare(1, S1_BASE + 32'h14, d1);
                write_and_score(1, S1_BASE + 32'h14, 32'hb1b1_0002, 4'hf);
                read_and_compare(1, S0_BASE + 32'h0c, d1);
            end
        join
    endtask

    task automatic pause_drain();
        axil_pkg::data_t data;
        logic            wr_done;
        logic            rd_done;
        wr_done = 1'b0;
        rd_done = 1'b0;
        fork
            begin
                write_and_score(0, S0_BASE + 32'h30, 32'h0bad_f00d, 4'hf);
                wr_done = 1'b1;
            end
            begin
                read_and_compare(1, S1_BASE + 32'h14, data);
                rd_done = 1'b1;
            end
            begin
                repeat (2) @(negedge clk);
                pause_req = 1'b1; // both requests sit inside the interconnect now.
                while (!(wr_done && rd_done)) begin
                    #1;
                    check(pause_ack, 1'b0, "pause acknowledge with traffic in flight");
                    @(negedge clk);
                end
            end
        join
        while (!pause_ack) begin
            @(negedge clk);
        end
        fork
            write_and_score(0, S0_BASE + 32'h38, 32'h600d_cafe, 4'hf);
            begin
                repeat (20) begin
                    @(negedge clk);
                    #1;
                    check(mgr_resp[0].aw_ready, 1'b0, "request accepted during pause");
                    check(pause_ack, 1'b1, "pause acknowledge held");
                end
                @(negedge clk);
                pause_req = 1'b0;
                @(negedge clk);
                #1;
                check(pause_ack, 1'b0, "pause acknowledge after release");
            end
        join
    endtask

    task automatic random_traffic(input int m, input logic [31:0] seed);
        logic [31:0]     state;
        axil_pkg::addr_t addr;
        axil_pkg::data_t data;
        state = seed;
        for (int i = 0; i < 20; i++) begin
            state = lcg(state);
            case (state[21:20])
                2'd0:    addr = S0_BASE;
                2'd1:    addr = S1_BASE;
                2'd2:    addr = 32'h3000_0000;
                default: addr = S0_BASE + RULE_SIZE;
            endcase
            addr = addr + {state[12:8], 1'(m), 2'b00}; // word parity follows the manager.
            if (state[24]) begin
                write_and_score(m, addr, lcg(state), state[31:28]);
            end else begin
                read_and_compare(m, addr, data);
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        pause_req = 1'b0;
        mgr_req   = '0;
        addr_map[0] = '{idx: 1'b0, start_addr: S0_BASE, end_addr: S0_BASE + RULE_SIZE};
        addr_map[1] = '{idx: 1'b1, start_addr: S1_BASE, end_addr: S1_BASE + RULE_SIZE};
        for (int i = 0; i < 64; i++) begin
            shadow[0][i] = FILL0 ^ (32'(i) << 2);
            shadow[1][i] = FILL1 ^ (32'(i) << 2);
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        route_and_offset();
        decode_miss();
        partial_strobes();
        concurrent_traffic();
        pause_drain();
        fork
            random_traffic(0, SEED);
            random_traffic(1, lcg(~SEED));
        join
        $display("TESTS PASSED");
        $finish;
    end

endmodule
